// File: Bender.yml
package:
  name: uart_loopback

sources:
  - verilog/uart_cfg_pkg.sv
  - verilog/uart_types_pkg.sv
  - verilog/uart_tx_request.sv
  - verilog/uart_tx_shifter.sv
  - verilog/uart_rx_sampler.sv
  - verilog/uart_loopback.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_uart_loopback.sv

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk, // tx_clk for the DUT
	output logic o_reset // reset_tx, active high
);

	localparam time HALF_PERIOD = 4ns; // 8 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		o_clk = 1'b0;
		o_reset = 1'b1; // held from time zero
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset <= 1'b0; // released on a rising edge like the other inputs
	end

	always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// File: tests/tb_uart_loopback.sv
`timescale 1ns/1ps

module tb_uart_loopback;

	import uart_cfg_pkg::*;

	localparam int WORD_COUNT = 20; // random words in the main loop
	localparam logic [15:0] SEED = 16'd18;
	localparam logic [15:0] TAPS = 16'hB400; // 16-bit galois feedback
	localparam int TIMEOUT = 400; // cycles allowed for any single wait
	localparam int BUSY_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;

	logic tx_clk;
	logic reset_tx;
	logic i_enable;
	logic [DATA_WIDTH-1:0] i_data;
	logic o_serial;
	logic o_busy;
	logic o_rx_valid;
	logic [DATA_WIDTH-1:0] o_rx_data;
	logic o_rx_error;

	logic [15:0] lfsr_q = SEED;
	logic [DATA_WIDTH-1:0] expect_q[$]; // words sent but not yet received
	logic [DATA_WIDTH-1:0] compare_word;
	int error_count = 0;
	int timeout_count = 0;
	int rx_count = 0; // receive pulses seen
	int sent_count = 0;

	tb_clock_gen clk0 (.o_clk(tx_clk), .o_reset(reset_tx));

	uart_loopback dut0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_enable(i_enable),
		.i_data(i_data),
		.o_serial(o_serial),
		.o_busy(o_busy),
		.o_rx_valid(o_rx_valid),
		.o_rx_data(o_rx_data),
		.o_rx_error(o_rx_error)
	);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1); // shift right, fold taps on a one
	endfunction

	// start 0, data lsb first, even parity, stop 1
	function automatic logic [FRAME_BITS-1:0] ref_frame(input logic [DATA_WIDTH-1:0] d);
		logic [FRAME_BITS-1:0] f;
		logic par;
		par = 1'b0;
		for (int b = 0; b < DATA_WIDTH; b++) begin
			par = par ^ d[b]; // even parity bit makes total ones even
		end
		f[0] = 1'b0;
		for (int b = 0; b < DATA_WIDTH; b++) begin
			f[b + 1] = d[b];
		end
		f[DATA_WIDTH + 1] = par;
		f[DATA_WIDTH + 2] = 1'b1;
		return f;
	endfunction

	task automatic draw_word(output logic [DATA_WIDTH-1:0] w);
		for (int b = 0; b < DATA_WIDTH; b++) begin
			lfsr_q = lfsr_step(lfsr_q); // one step per bit
			w[b] = lfsr_q[0];
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d timeouts, %0d words sent, %0d received",
			error_count, timeout_count, sent_count, rx_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// strobe one request and check busy around it
	task automatic send_request(input logic [DATA_WIDTH-1:0] w);
		@(negedge tx_clk);
		if (rx_count != sent_count) begin
			$display("CHECK FAILED at %0t: %0d receives for %0d words", $time, rx_count, sent_count);
			error_count++;
		end
		if (o_busy !== 1'b0) begin
			$display("CHECK FAILED at %0t: busy high before request", $time);
			error_count++;
		end
		@(posedge tx_clk);
		i_enable <= 1'b1;
		i_data <= w;
		@(negedge tx_clk);
		if (o_busy !== 1'b0) begin // enable not yet clocked in
			$display("CHECK FAILED at %0t: busy rose before enable was taken", $time);
			error_count++;
		end
		@(posedge tx_clk);
		i_enable <= 1'b0; // single-cycle strobe
		@(negedge tx_clk);
		if (o_busy !== 1'b1) begin
			$display("CHECK FAILED at %0t: busy not high the cycle after enable", $time);
			error_count++;
		end
	endtask

	// sample each bit mid-period and count busy cycles from the start bit
	task automatic check_frame(input logic [DATA_WIDTH-1:0] w);
		logic [FRAME_BITS-1:0] expect_bits;
		logic [FRAME_BITS-1:0] seen;
		int waited;
		int idx;
		expect_bits = ref_frame(w);
		seen = '1;
		waited = 0;
		@(negedge tx_clk);
		while (o_serial === 1'b1 && waited < TIMEOUT) begin
			@(negedge tx_clk);
			waited++;
		end
		if (o_serial !== 1'b0) begin
			$display("timed out at %0t waiting for the start bit", $time);
			timeout_count++;
		end else begin
			idx = 0; // this negedge is the first cycle of the start bit
			while (o_busy === 1'b1 && idx < TIMEOUT) begin
				if (idx % CLOCKS_PER_BIT == CLOCKS_PER_BIT / 2
						&& idx / CLOCKS_PER_BIT < FRAME_BITS) begin
					seen[idx / CLOCKS_PER_BIT] = o_serial;
				end
				idx++;
				@(negedge tx_clk);
			end
			if (o_busy === 1'b1) begin
				$display("timed out at %0t waiting for busy to drop", $time);
				timeout_count++;
			end else begin
				if (seen !== expect_bits) begin
					$display("CHECK FAILED at %0t: frame %b, expected %b",
						$time, seen, expect_bits);
					error_count++;
				end
				if (idx != BUSY_CYCLES) begin
					$display("CHECK FAILED at %0t: busy for %0d cycles after start, expected %0d",
						$time, idx, BUSY_CYCLES);
					error_count++;
				end
			end
		end
	endtask

	task automatic wait_receive(input int target);
		int n;
		n = 0;
		while (rx_count < target && n < TIMEOUT) begin
			@(posedge tx_clk); // counter moves on negedges only
			n++;
		end
		if (rx_count < target) begin
			$display("timed out at %0t waiting for rx valid", $time);
			timeout_count++;
		end
	endtask

	// second strobe mid-frame must be dropped
	task automatic check_ignored_strobe();
		logic [DATA_WIDTH-1:0] word;
		logic [DATA_WIDTH-1:0] ignored_word;
		draw_word(word);
		ignored_word = ~word; // always differs from the real word
		expect_q.push_back(word);
		send_request(word);
		fork
			check_frame(word);
			begin
				repeat (3 * CLOCKS_PER_BIT) @(posedge tx_clk);
				i_enable <= 1'b1;
				i_data <= ignored_word;
				@(posedge tx_clk);
				i_enable <= 1'b0;
			end
		join
		sent_count++;
		if (timeout_count == 0) begin
			wait_receive(sent_count);
		end
		if (timeout_count == 0) begin
			for (int c = 0; c < 4 * FRAME_BITS; c++) begin // line must stay idle
				@(negedge tx_clk);
				if (o_serial !== 1'b1 || o_busy !== 1'b0) begin
					$display("CHECK FAILED at %0t: activity after the ignored strobe", $time);
					error_count++;
				end
			end
			if (rx_count != sent_count || expect_q.size() != 0) begin
				$display("CHECK FAILED at %0t: %0d receives for %0d words",
					$time, rx_count, sent_count);
				error_count++;
			end
		end
	endtask

	// compare every receive pulse against the oldest outstanding word
	always @(negedge tx_clk) begin
		if (reset_tx === 1'b0 && o_rx_valid === 1'b1) begin
			rx_count = rx_count + 1;
			if (expect_q.size() == 0) begin
				$display("CHECK FAILED at %0t: rx valid with no word outstanding", $time);
				error_count++;
			end else begin
				compare_word = expect_q.pop_front();
				if (o_rx_data !== compare_word) begin
					$display("CHECK FAILED at %0t: rx data %h, expected %h",
						$time, o_rx_data, compare_word);
					error_count++;
				end
				if (o_rx_error !== 1'b0) begin
					$display("CHECK FAILED at %0t: rx error flag set", $time);
					error_count++;
				end
			end
		end
	end

	initial begin : stimulus
		logic [DATA_WIDTH-1:0] word;
		int n;
		i_enable = 1'b0;
		i_data = '0;
		n = 0;
		while (reset_tx !== 1'b0 && n < TIMEOUT) begin
			@(posedge tx_clk);
			n++;
		end
		if (reset_tx !== 1'b0) begin
			$display("reset was never released");
			timeout_count++;
		end else begin
			@(negedge tx_clk);
			if (o_busy !== 1'b0 || o_rx_valid !== 1'b0
					|| o_rx_error !== 1'b0 || o_serial !== 1'b1) begin
				$display("CHECK FAILED at %0t: outputs after reset busy=%b valid=%b err=%b serial=%b",
					$time, o_busy, o_rx_valid, o_rx_error, o_serial);
				error_count++;
			end
			for (int k = 0; k < WORD_COUNT && timeout_count == 0; k++) begin
				draw_word(word);
				expect_q.push_back(word);
				send_request(word);
				check_frame(word);
				sent_count++;
				if (timeout_count == 0) begin
					wait_receive(sent_count);
				end
			end
			if (timeout_count == 0) begin
				check_ignored_strobe();
			end
		end
		finish_run();
	end

endmodule

// File: verilog/uart_cfg_pkg.sv
package uart_cfg_pkg;

	// word and frame layout
	localparam int DATA_WIDTH = 8; // data bits per word
	localparam int FRAME_BITS = 1 + DATA_WIDTH + 1 + 1; // start + data + parity + stop

	// bit timing in tx_clk cycles
	localparam int CLOCKS_PER_BIT = 8; // one bit period
	localparam int SYNC_STAGES = 3; // rx line synchronizer depth

	// parity sense, 0 gives even parity
	localparam bit PARITY_ODD = 1'b0;

	// counter widths
	localparam int BIT_CNT_WIDTH = $clog2(FRAME_BITS); // counts bits of a frame
	localparam int CYC_CNT_WIDTH = $clog2(CLOCKS_PER_BIT); // counts cycles inside a bit

endpackage

// File: verilog/uart_loopback.sv
`timescale 1ns/1ps

module uart_loopback (
	input logic tx_clk,
	input logic reset_tx,
	input logic i_enable, // request strobe
	input logic [uart_cfg_pkg::DATA_WIDTH-1:0] i_data,
	output logic o_serial, // tx line, also looped into rx
	output logic o_busy,
	output logic o_rx_valid,
	output logic [uart_cfg_pkg::DATA_WIDTH-1:0] o_rx_data,
	output logic o_rx_error // parity or stop error
);

	import uart_types_pkg::*;

	tx_frame_t frame; // request -> shifter
	logic frame_pending;
	logic frame_taken; // shifter -> request
	rx_result_t rx_result;

	uart_tx_request req0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_enable(i_enable),
		.i_data(i_data),
		.i_busy(o_busy),
		.i_frame_taken(frame_taken),
		.o_frame(frame),
		.o_frame_pending(frame_pending)
	);

	uart_tx_shifter shf0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_frame(frame),
		.i_frame_pending(frame_pending),
		.o_frame_taken(frame_taken),
		.o_serial(o_serial),
		.o_busy(o_busy)
	);

	uart_rx_sampler rx0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_serial(o_serial), // loopback
		.o_valid(o_rx_valid),
		.o_result(rx_result)
	);

	assign o_rx_data = rx_result.data;
	assign o_rx_error = rx_result.parity_error | rx_result.stop_error;

endmodule

// File: verilog/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler (
	input logic tx_clk,
	input logic reset_tx,
	input logic i_serial, // raw serial line
	output logic o_valid, // one-cycle pulse at stop-bit sample
	output uart_types_pkg::rx_result_t o_result
);

	import uart_cfg_pkg::*;
	import uart_types_pkg::*;

	logic [SYNC_STAGES-1:0] sync_q; // line synchronizer chain
	logic line; // synchronized line
	logic line_q; // previous synchronized value
	logic fall; // start edge
	logic sample; // mid-bit strobe
	rx_state_t state_q;
	logic [CYC_CNT_WIDTH-1:0] cyc_q; // cycle within bit
	logic [BIT_CNT_WIDTH-1:0] bit_q; // data bits taken so far
	logic [DATA_WIDTH-1:0] data_q; // shift in from the top, lsb first
	logic parity_q; // received parity bit
	logic valid_q;
	rx_result_t result_q;

	assign line = sync_q[SYNC_STAGES-1];
	assign fall = line_q & ~line; // high to low on synced line
	assign sample = (cyc_q == CYC_CNT_WIDTH'(CLOCKS_PER_BIT / 2));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1; // idle line level
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_q <= line;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q <= RX_IDLE;
			cyc_q <= '0;
			bit_q <= '0;
			valid_q <= 1'b0;
			result_q <= '0;
		end else begin
			valid_q <= 1'b0; // default, pulses once per frame
			if (cyc_q == CYC_CNT_WIDTH'(CLOCKS_PER_BIT - 1)) begin
				cyc_q <= '0;
			end else begin
				cyc_q <= cyc_q + 1'b1;
			end
			unique case (state_q)
				RX_IDLE: begin
					if (fall) begin
						cyc_q <= CYC_CNT_WIDTH'(1); // edge cycle counts as cycle 0
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (sample) begin
						if (line) begin
							state_q <= RX_IDLE; // glitch, not a start bit
						end else begin
							bit_q <= '0;
							state_q <= RX_DATA;
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						data_q <= {line, data_q[DATA_WIDTH-1:1]};
						bit_q <= bit_q + 1'b1;
						if (bit_q == BIT_CNT_WIDTH'(DATA_WIDTH - 1)) begin
							state_q <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						parity_q <= line;
						state_q <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (sample) begin
						result_q.data <= data_q;
						result_q.parity_error <= ((^data_q) ^ PARITY_ODD) != parity_q; // recomputed vs received
						result_q.stop_error <= ~line; // stop must be high
						valid_q <= 1'b1;
						state_q <= RX_IDLE; // rest of stop bit is idle level
					end
				end
				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

	assign o_valid = valid_q;
	assign o_result = result_q;

endmodule

// File: verilog/uart_tx_request.sv
`timescale 1ns/1ps

module uart_tx_request (
	input logic tx_clk,
	input logic reset_tx,
	input logic i_enable, // single-cycle request strobe
	input logic [uart_cfg_pkg::DATA_WIDTH-1:0] i_data, // word to send
	input logic i_busy, // transmitter busy, requests dropped
	input logic i_frame_taken, // shifter loaded the frame this cycle
	output uart_types_pkg::tx_frame_t o_frame,
	output logic o_frame_pending
);

	import uart_cfg_pkg::*;
	import uart_types_pkg::*;

	logic accept; // request honoured this cycle
	logic parity_bit; // parity of incoming word
	tx_frame_t frame_q; // framed word waiting for the shifter
	logic pending_q;

	assign accept = i_enable & ~i_busy; // ignored while busy
	assign parity_bit = (^i_data) ^ PARITY_ODD; // xor of data, flipped for odd

	always_ff @(posedge tx_clk) begin
		if (accept) begin
			frame_q.stop <= 1'b1;
			frame_q.parity <= parity_bit;
			frame_q.data <= i_data;
			frame_q.start <= 1'b0;
		end
	end

	// pending stays up until the shifter takes the frame
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			pending_q <= 1'b0;
		end else if (accept) begin
			pending_q <= 1'b1; // busy gating keeps this to one frame
		end else if (i_frame_taken) begin
			pending_q <= 1'b0; // low the cycle after the load
		end
	end

	assign o_frame = frame_q;
	assign o_frame_pending = pending_q;

endmodule

// File: verilog/uart_tx_shifter.sv
`timescale 1ns/1ps

module uart_tx_shifter (
	input logic tx_clk,
	input logic reset_tx,
	input uart_types_pkg::tx_frame_t i_frame, // frame from request stage
	input logic i_frame_pending, // a frame is waiting
	output logic o_frame_taken, // pulse in the cycle the frame is loaded
	output logic o_serial, // serial line, idles high
	output logic o_busy
);

	import uart_cfg_pkg::*;
	import uart_types_pkg::*;

	tx_state_t state_q;
	logic [CYC_CNT_WIDTH-1:0] cyc_q; // cycle within current bit
	logic [BIT_CNT_WIDTH-1:0] bit_q; // bit index within frame
	logic [FRAME_BITS-1:0] shift_q; // bit 0 is on the line
	logic bit_end; // last cycle of a bit period
	logic frame_end; // last cycle of the stop bit

	assign bit_end = (cyc_q == CYC_CNT_WIDTH'(CLOCKS_PER_BIT - 1));
	assign frame_end = bit_end && (bit_q == BIT_CNT_WIDTH'(FRAME_BITS - 1));

	assign o_frame_taken = (state_q == TX_IDLE) && i_frame_pending; // load happens at this edge

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q <= TX_IDLE;
			cyc_q <= '0;
			bit_q <= '0;
			shift_q <= '1; // line high out of reset
		end else begin
			unique case (state_q)
				TX_IDLE: begin
					if (i_frame_pending) begin
						shift_q <= i_frame; // start bit shows next cycle
						cyc_q <= '0;
						bit_q <= '0;
						state_q <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (bit_end) begin
						cyc_q <= '0;
						shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]}; // refill with idle level
						if (frame_end) begin
							state_q <= TX_IDLE; // stop bit done
						end else begin
							bit_q <= bit_q + 1'b1;
						end
					end else begin
						cyc_q <= cyc_q + 1'b1;
					end
				end
				default: begin
					state_q <= TX_IDLE;
				end
			endcase
		end
	end

	// Busy covers the pending frame as well, so a new request is
	// refused from the cycle after the accepted one until the stop bit ends.
	assign o_busy = i_frame_pending | (state_q == TX_SEND);
	assign o_serial = shift_q[0];

endmodule

// File: verilog/uart_types_pkg.sv
package uart_types_pkg;

	import uart_cfg_pkg::*;

	// transmit shifter FSM
	typedef enum logic {
		TX_IDLE, // line high, waiting for a pending frame
		TX_SEND // frame going out bit by bit
	} tx_state_t;

	// receive sampler FSM
	typedef enum logic [2:0] {
		RX_IDLE, // waiting for falling edge
		RX_START, // confirm start bit at mid-bit
		RX_DATA, // data bits, lsb first
		RX_PARITY, // parity bit
		RX_STOP // stop bit, result goes out here
	} rx_state_t;

	// start sits at bit 0 so the frame leaves from the lsb
	typedef struct packed {
		logic stop; // always 1
		logic parity; // parity over data
		logic [DATA_WIDTH-1:0] data; // payload, lsb sent first
		logic start; // always 0
	} tx_frame_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data; // received word
		logic parity_error; // parity bit did not match
		logic stop_error; // stop bit sampled low
	} rx_result_t;

endpackage

// File: vlog.f
verilog/uart_cfg_pkg.sv
verilog/uart_types_pkg.sv
verilog/uart_tx_request.sv
verilog/uart_tx_shifter.sv
verilog/uart_rx_sampler.sv
verilog/uart_loopback.sv
tests/tb_clock_gen.sv
tests/tb_uart_loopback.sv
